/* sources.f */
hdl/uart_regs_pkg.sv
hdl/uart_frame_pkg.sv
hdl/byte_fifo.sv
hdl/uart_tx_path.sv
hdl/uart_rx_path.sv
hdl/uart_regs.sv
hdl/uart_top.sv
dv/uart_chk.sv
dv/uart_tb.sv

/* run.sh */
#!/bin/sh
# Build the UART testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module uart_tb \
  -f sources.f -o uart_sim &&
  ./obj_dir/uart_sim > sim.log 2>&1 ||
  echo "Simulation FAILED" >> sim.log
cat sim.log
! grep -q "Simulation FAILED" sim.log

/* dv/uart_tests.txt */
# name op addr data expect, all numbers in hex
# W writes data, R compares the bits set in data, B waits data bit times
rst_div      R 6 ffffffff 00000055
rst_txctrl   R 2 ffffffff 00000000
rst_rxctrl   R 3 ffffffff 00000000
rst_ie       R 4 ffffffff 00000000
rst_ip       R 5 ffffffff 00000000
rst_rxdata   R 1 80000000 80000000
set_div      W 6 ffff001f 00000000
rt_div       R 6 ffffffff 0000001f
set_txctrl   W 2 fffffffe 00000000
rt_txctrl    R 2 ffffffff 00070002
set_rxctrl   W 3 fffffffe 00000000
rt_rxctrl    R 3 ffffffff 00070000
set_ie       W 4 ffffffff 00000000
rt_ie        R 4 ffffffff 00000003
lb_txctrl    W 2 00000003 00000000
lb_rxctrl    W 3 00000001 00000000
lb_push0     W 0 000000a5 00000000
lb_push1     W 0 0000003c 00000000
lb_push2     W 0 000000f0 00000000
lb_wait      B 0 00000024 00000000
lb_pop0      R 1 800000ff 000000a5
lb_pop1      R 1 800000ff 0000003c
lb_pop2      R 1 800000ff 000000f0
lb_empty     R 1 80000000 80000000
full_txctrl  W 2 00000002 00000000
full_push1   W 0 00000001 00000000
full_push2   W 0 00000002 00000000
full_push3   W 0 00000003 00000000
full_push4   W 0 00000004 00000000
full_push5   W 0 00000005 00000000
full_push6   W 0 00000006 00000000
full_push7   W 0 00000007 00000000
full_push8   W 0 00000008 00000000
full_push9   W 0 00000009 00000000
full_flag    R 0 80000000 80000000
full_txen    W 2 00000003 00000000
full_wait    B 0 0000005f 00000000
full_pop1    R 1 800000ff 00000001
full_pop2    R 1 800000ff 00000002
full_pop3    R 1 800000ff 00000003
full_pop4    R 1 800000ff 00000004
full_pop5    R 1 800000ff 00000005
full_pop6    R 1 800000ff 00000006
full_pop7    R 1 800000ff 00000007
full_pop8    R 1 800000ff 00000008
full_empty   R 1 80000000 80000000
wm_txctrl    W 2 00020001 00000000
wm_rxctrl    W 3 00010001 00000000
wm_ie        W 4 00000003 00000000
wm_tx_empty  R 5 ffffffff 00000001
wm_push0     W 0 0000005a 00000000
wm_push1     W 0 000000c3 00000000
wm_wait      B 0 0000001a 00000000
wm_rx_two    R 5 ffffffff 00000003
wm_pop0      R 1 800000ff 0000005a
wm_rx_one    R 5 ffffffff 00000001
wm_pop1      R 1 800000ff 000000c3

/* dv/uart_tb.sv */
// UART peripheral testbench
// Clock, reset and bus accesses read from the test file
// Loopback of txd to rxd, read data checks and final report
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

  // Divisor used by the tests, one bit every 32 clocks
  localparam int TEST_DIV = 31;
  localparam int BIT_CYCLES = TEST_DIV + 1;
  localparam int MARGIN_CYCLES = 2000;
  localparam int RESPONSE_CYCLES = 4;

  typedef struct packed {
    logic [7:0]  op;
    logic [2:0]  addr;
    logic [31:0] data;
    logic [31:0] exp_data;
  } access_t;

  logic        clock;
  logic        reset;
  logic        rd_en;
  logic        wr_en;
  logic [2:0]  addr;
  logic [31:0] wr_data;
  logic [31:0] rd_data;
  logic        rd_valid;
  logic        txd;

  access_t     tests [$];
  string       names [$];
  int          errors;
  int          checks;
  int          cycle_count;
  int          timeout_cycles;

  // Serial output looped back to the receiver
  uart_top uut (
    .clock    (clock),
    .reset    (reset),
    .rd_en    (rd_en),
    .wr_en    (wr_en),
    .addr     (addr),
    .wr_data  (wr_data),
    .rxd      (txd),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .txd      (txd)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > timeout_cycles) begin
      $display("Timeout: tests did not finish within %0d cycles", timeout_cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic read_tests();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    access_t     acc;
    fd = $fopen("dv/uart_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test file dv/uart_tests.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // Skip comment and blank lines
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %s %h %h %h", name, op, a, d, e);
        if (n == 5) begin
          acc.op       = op.getc(0);
          acc.addr     = a[2:0];
          acc.data     = d;
          acc.exp_data = e;
          names.push_back(name);
          tests.push_back(acc);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic bus_write(input logic [2:0] a, input logic [31:0] d);
    @(posedge clock);
    wr_en   <= 1'b1;
    addr    <= a;
    wr_data <= d;
    @(posedge clock);
    wr_en <= 1'b0;
  endtask

  // Response sampled at the falling edge
  task automatic bus_read(input logic [2:0] a, output logic [31:0] value, output logic got);
    got   = 1'b0;
    value = '0;
    @(posedge clock);
    rd_en <= 1'b1;
    addr  <= a;
    @(posedge clock);
    rd_en <= 1'b0;
    for (int k = 0; k < RESPONSE_CYCLES && !got; k++) begin
      @(negedge clock);
      if (rd_valid) begin
        got   = 1'b1;
        value = rd_data;
      end
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
    end
  endtask

  initial begin
    access_t     acc;
    logic [31:0] value;
    logic        got;
    void'($urandom(10114));
    reset          = 1'b1;
    rd_en          = 1'b0;
    wr_en          = 1'b0;
    addr           = '0;
    wr_data        = '0;
    errors         = 0;
    checks         = 0;
    cycle_count    = 0;
    timeout_cycles = MARGIN_CYCLES;
    read_tests();
    timeout_cycles = tests.size() * 20 * BIT_CYCLES + MARGIN_CYCLES;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    foreach (tests[i]) begin
      acc = tests[i];
      case (acc.op)
        "W": bus_write(acc.addr, acc.data);
        "R": begin
          bus_read(acc.addr, value, got);
          if (!got) begin
            errors++;
            $display("No read response for test %s at address %0d", names[i], acc.addr);
          end else begin
            // For reads the data column masks the compared bits
            compare_value(names[i], acc.exp_data & acc.data, value & acc.data);
          end
        end
        "B": repeat (acc.data * BIT_CYCLES) @(posedge clock);
        default: begin
          errors++;
          $display("Unknown operation in test %s", names[i]);
        end
      endcase
      repeat ($urandom_range(3, 0)) @(posedge clock);
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/uart_chk.sv */
// Bound assertions for the UART
// Read response and strobes at the bus input of the register block
// Serial line level while the transmitter is idle
`timescale 1ns/1ps
`default_nettype none

module uart_chk (
  input logic clock,
  input logic reset,
  input logic rd_strobe,
  input logic wr_strobe,
  input logic rd_valid,
  input logic tx_idle,
  input logic txd
);

  // Strobe is registered once, read data follows one cycle later
  assert property (@(posedge clock) disable iff (reset) $past(rd_strobe) |=> rd_valid)
    else $error("rd_valid missing after a read strobe");

  assert property (@(posedge clock) disable iff (reset) rd_valid |-> $past(rd_strobe, 2))
    else $error("rd_valid without a preceding read strobe");

  assert property (@(posedge clock) disable iff (reset) !(rd_strobe && wr_strobe))
    else $error("read and write strobes high in the same cycle");

  // Line rests at the stop level between frames
  assert property (@(posedge clock) disable iff (reset) tx_idle |-> txd)
    else $error("txd low while the transmitter is idle");

endmodule

bind uart_regs uart_chk u_regs_chk (
  .clock     (clock),
  .reset     (reset),
  .rd_strobe (bus.rd),
  .wr_strobe (bus.wr),
  .rd_valid  (rd_valid),
  .tx_idle   (1'b0),
  .txd       (1'b1)
);

bind uart_tx_path uart_chk u_tx_chk (
  .clock     (clock),
  .reset     (reset),
  .rd_strobe (1'b0),
  .wr_strobe (1'b0),
  .rd_valid  (1'b0),
  .tx_idle   (state == TX_IDLE),
  .txd       (txd)
);

`default_nettype wire

/* hdl/uart_top.sv */
// UART peripheral top level
// Register block with the transmit and receive paths side by side
`timescale 1ns/1ps
`default_nettype none

module uart_top
  import uart_regs_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        rd_en,
  input  logic        wr_en,
  input  logic [2:0]  addr,
  input  logic [31:0] wr_data,
  input  logic        rxd,
  output logic [31:0] rd_data,
  output logic        rd_valid,
  output logic        txd
);

  bus_req_t   bus;
  tx_ctrl_t   tx_ctrl;
  rx_ctrl_t   rx_ctrl;
  tx_status_t tx_status;
  rx_status_t rx_status;
  logic [15:0] div;
  logic        tx_push;
  logic [7:0]  tx_byte;
  logic        rx_pop;

  assign bus = '{rd: rd_en, wr: wr_en, addr: addr, data: wr_data};

  uart_regs u_regs (
    .clock     (clock),
    .reset     (reset),
    .bus       (bus),
    .tx_status (tx_status),
    .rx_status (rx_status),
    .tx_ctrl   (tx_ctrl),
    .rx_ctrl   (rx_ctrl),
    .div       (div),
    .tx_push   (tx_push),
    .tx_byte   (tx_byte),
    .rx_pop    (rx_pop),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

  uart_tx_path u_tx (
    .clock     (clock),
    .reset     (reset),
    .ctrl      (tx_ctrl),
    .div       (div),
    .push      (tx_push),
    .push_byte (tx_byte),
    .status    (tx_status),
    .txd       (txd)
  );

  uart_rx_path u_rx (
    .clock  (clock),
    .reset  (reset),
    .ctrl   (rx_ctrl),
    .div    (div),
    .rxd    (rxd),
    .pop    (rx_pop),
    .status (rx_status)
  );

endmodule

`default_nettype wire

/* hdl/uart_regs.sv */
// Register block of the UART
// Bus input stage and address decode
// Control, interrupt enable and baud divisor registers
// Interrupt pending bits and registered read data
`timescale 1ns/1ps
`default_nettype none

module uart_regs
  import uart_regs_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  bus_req_t    bus,
  input  tx_status_t  tx_status,
  input  rx_status_t  rx_status,
  output tx_ctrl_t    tx_ctrl,
  output rx_ctrl_t    rx_ctrl,
  output logic [15:0] div,
  output logic        tx_push,
  output logic [7:0]  tx_byte,
  output logic        rx_pop,
  output logic [31:0] rd_data,
  output logic        rd_valid
);

  bus_req_t    bus_q;
  uart_addr_e  addr;
  // Bit 0 is txwm, bit 1 is rxwm
  logic [1:0]  ie;
  logic [1:0]  ip;
  logic [31:0] rd_next;

  // Strobe sampled here, acted on at the following edge
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bus_q <= '0;
    end else begin
      bus_q <= bus;
    end
  end

  assign addr    = uart_addr_e'(bus_q.addr);
  assign tx_push = bus_q.wr && addr == ADDR_TXDATA;
  assign tx_byte = bus_q.data[7:0];
  // Pop in the same cycle the head is captured
  assign rx_pop  = bus_q.rd && addr == ADDR_RXDATA;

  assign ip = {rx_status.above_wm & ie[1], tx_status.below_wm & ie[0]};

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tx_ctrl <= '0;
      rx_ctrl <= '0;
      ie      <= '0;
      div     <= DIV_RESET;
    end else if (bus_q.wr) begin
      case (addr)
        ADDR_TXCTRL: begin
          tx_ctrl.txcnt <= bus_q.data[WM_LSB +: 3];
          tx_ctrl.nstop <= bus_q.data[1];
          tx_ctrl.txen  <= bus_q.data[0];
        end
        ADDR_RXCTRL: begin
          rx_ctrl.rxcnt <= bus_q.data[WM_LSB +: 3];
          rx_ctrl.rxen  <= bus_q.data[0];
        end
        ADDR_IE:  ie  <= bus_q.data[1:0];
        ADDR_DIV: div <= bus_q.data[15:0];
        default: ;
      endcase
    end
  end

  // Unused bits and address 7 read as zero
  always_comb begin
    rd_next = '0;
    case (addr)
      ADDR_TXDATA: rd_next[31] = tx_status.full;
      ADDR_RXDATA: begin
        rd_next[31]  = rx_status.empty;
        rd_next[7:0] = rx_status.head;
      end
      ADDR_TXCTRL: begin
        rd_next[WM_LSB +: 3] = tx_ctrl.txcnt;
        rd_next[1]           = tx_ctrl.nstop;
        rd_next[0]           = tx_ctrl.txen;
      end
      ADDR_RXCTRL: begin
        rd_next[WM_LSB +: 3] = rx_ctrl.rxcnt;
        rd_next[0]           = rx_ctrl.rxen;
      end
      ADDR_IE:  rd_next[1:0]  = ie;
      ADDR_IP:  rd_next[1:0]  = ip;
      ADDR_DIV: rd_next[15:0] = div;
      default: ;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= bus_q.rd;
    end
  end

  // Holds the last read value between reads
  always_ff @(posedge clock) begin
    if (bus_q.rd) begin
      rd_data <= rd_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/uart_rx_path.sv */
// Receive path
// Input synchronizer and 16x oversampling tick
// Start-bit check, mid-bit sampling and receive FIFO
`timescale 1ns/1ps
`default_nettype none

module uart_rx_path
  import uart_regs_pkg::*;
  import uart_frame_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  rx_ctrl_t    ctrl,
  input  logic [15:0] div,
  input  logic        rxd,
  input  logic        pop,
  output rx_status_t  status
);

  logic                 rxd_meta;
  logic                 rxd_sync;
  logic [15:0]          div_q;
  logic [11:0]          os_cnt;
  logic                 div_change;
  logic                 os_tick;
  rx_state_e            state;
  logic [TICK_W-1:0]    phase;
  logic                 phase_last;
  logic [BIT_W-1:0]     bit_cnt;
  logic [DATA_BITS-1:0] shift;
  logic                 push;

  byte_fifo u_fifo (
    .clock       (clock),
    .reset       (reset),
    .push        (push),
    .push_data   (shift),
    .pop         (pop),
    .head        (status.head),
    .level       (ctrl.rxcnt),
    .empty       (status.empty),
    .full        (),
    .below_level (),
    .above_level (status.above_wm)
  );

  // Two-flop synchronizer, line idles high
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= STOP_LEVEL;
      rxd_sync <= STOP_LEVEL;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  // Oversampling tick every div[15:4]+1 clocks
  assign div_change = (div != div_q);
  assign os_tick    = !div_change && (os_cnt == div[15:4]);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      div_q  <= DIV_RESET;
      os_cnt <= '0;
    end else begin
      div_q <= div;
      if (div_change || os_cnt == div[15:4]) begin
        os_cnt <= '0;
      end else begin
        os_cnt <= os_cnt + 1'b1;
      end
    end
  end

  assign phase_last = (phase == TICK_W'(OVERSAMPLE - 1));

  // Byte is stored at the middle of the first stop bit
  assign push = os_tick && state == RX_STOP && phase_last &&
                rxd_sync == STOP_LEVEL && ctrl.rxen;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= RX_IDLE;
      phase   <= '0;
      bit_cnt <= '0;
    end else if (os_tick) begin
      case (state)
        RX_IDLE: begin
          if (rxd_sync == START_LEVEL) begin
            state <= RX_START;
            phase <= '0;
          end
        end
        RX_START: begin
          // Half a bit later the line must still be low
          if (phase == TICK_W'(HALF_BIT - 1)) begin
            phase   <= '0;
            bit_cnt <= '0;
            state   <= (rxd_sync == START_LEVEL) ? RX_DATA : RX_IDLE;
          end else begin
            phase <= phase + 1'b1;
          end
        end
        RX_DATA: begin
          phase <= phase + 1'b1;
          if (phase_last) begin
            if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
              state <= RX_STOP;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        RX_STOP: begin
          phase <= phase + 1'b1;
          if (phase_last) begin
            state <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clock) begin
    if (os_tick && state == RX_DATA && phase_last) begin
      shift <= {rxd_sync, shift[DATA_BITS-1:1]};
    end
  end

endmodule

`default_nettype wire

/* hdl/uart_tx_path.sv */
// Transmit path
// Transmit FIFO, baud tick generator and frame serializer
// Start bit, eight data bits LSB first, one or two stop bits
`timescale 1ns/1ps
`default_nettype none

module uart_tx_path
  import uart_regs_pkg::*;
  import uart_frame_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  tx_ctrl_t    ctrl,
  input  logic [15:0] div,
  input  logic        push,
  input  logic [7:0]  push_byte,
  output tx_status_t  status,
  output logic        txd
);

  logic [15:0]          div_q;
  logic [15:0]          baud_cnt;
  logic                 div_change;
  logic                 baud_tick;
  tx_state_e            state;
  logic [DATA_BITS-1:0] shift;
  logic [BIT_W-1:0]     bit_cnt;
  logic                 stop_left;
  logic                 start_frame;
  logic                 fifo_empty;
  logic [7:0]           fifo_head;

  byte_fifo u_fifo (
    .clock       (clock),
    .reset       (reset),
    .push        (push),
    .push_data   (push_byte),
    .pop         (start_frame),
    .head        (fifo_head),
    .level       (ctrl.txcnt),
    .empty       (fifo_empty),
    .full        (status.full),
    .below_level (status.below_wm),
    .above_level ()
  );

  // One tick every div+1 clocks, counter restarts on a new divisor
  assign div_change = (div != div_q);
  assign baud_tick  = !div_change && (baud_cnt == div);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      div_q    <= DIV_RESET;
      baud_cnt <= '0;
    end else begin
      div_q <= div;
      if (div_change || baud_cnt == div) begin
        baud_cnt <= '0;
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // Next frame may follow the last stop bit directly
  assign start_frame = baud_tick && ctrl.txen && !fifo_empty &&
                       (state == TX_IDLE || (state == TX_STOP && !stop_left));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= TX_IDLE;
      txd       <= STOP_LEVEL;
      bit_cnt   <= '0;
      stop_left <= 1'b0;
    end else if (start_frame) begin
      state <= TX_START;
      txd   <= START_LEVEL;
    end else if (baud_tick) begin
      case (state)
        TX_START: begin
          state   <= TX_DATA;
          txd     <= shift[0];
          bit_cnt <= '0;
        end
        TX_DATA: begin
          if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
            state     <= TX_STOP;
            txd       <= STOP_LEVEL;
            stop_left <= ctrl.nstop;
          end else begin
            txd     <= shift[0];
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          if (stop_left) begin
            stop_left <= 1'b0;
          end else begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Byte is taken from the FIFO head as it is popped
  always_ff @(posedge clock) begin
    if (start_frame) begin
      shift <= fifo_head;
    end else if (baud_tick && (state == TX_START || state == TX_DATA)) begin
      shift <= shift >> 1;
    end
  end

endmodule

`default_nettype wire

/* hdl/byte_fifo.sv */
// Eight-entry byte FIFO
// Circular buffer with occupancy count
// Watermark comparisons of the count against a level
`timescale 1ns/1ps
`default_nettype none

module byte_fifo
  import uart_regs_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  input  logic               push,
  input  logic [7:0]         push_data,
  input  logic               pop,
  output logic [7:0]         head,
  input  logic [FIFO_AW-1:0] level,
  output logic               empty,
  output logic               full,
  output logic               below_level,
  output logic               above_level
);

  logic [7:0]         mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               do_push;
  logic               do_pop;

  // Push into a full FIFO and pop from an empty one are ignored
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign head  = mem[rd_ptr];

  assign below_level = (count < {1'b0, level});
  assign above_level = (count > {1'b0, level});

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/uart_frame_pkg.sv */
// Serial line and frame definitions
// Transmitter and receiver state enums
// Oversampling factor, data bits and line levels
`default_nettype none

package uart_frame_pkg;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  localparam int OVERSAMPLE = 16;
  localparam int HALF_BIT = OVERSAMPLE / 2;
  localparam int TICK_W = $clog2(OVERSAMPLE);
  localparam int DATA_BITS = 8;
  localparam int BIT_W = $clog2(DATA_BITS);

  // Line idles at the stop level
  localparam logic START_LEVEL = 1'b0;
  localparam logic STOP_LEVEL = 1'b1;

endpackage

`default_nettype wire

/* hdl/uart_regs_pkg.sv */
// Register map and bus definitions of the UART peripheral
// Address enum, bus request, control and status structs
// Reset divisor and FIFO sizing
`default_nettype none

package uart_regs_pkg;

  typedef enum logic [2:0] {
    ADDR_TXDATA = 3'd0,
    ADDR_RXDATA = 3'd1,
    ADDR_TXCTRL = 3'd2,
    ADDR_RXCTRL = 3'd3,
    ADDR_IE     = 3'd4,
    ADDR_IP     = 3'd5,
    ADDR_DIV    = 3'd6
  } uart_addr_e;

  typedef struct packed {
    logic        rd;
    logic        wr;
    logic [2:0]  addr;
    logic [31:0] data;
  } bus_req_t;

  typedef struct packed {
    logic [2:0] txcnt;
    logic       nstop;
    logic       txen;
  } tx_ctrl_t;

  typedef struct packed {
    logic [2:0] rxcnt;
    logic       rxen;
  } rx_ctrl_t;

  typedef struct packed {
    logic full;
    logic below_wm;
  } tx_status_t;

  typedef struct packed {
    logic       empty;
    logic       above_wm;
    logic [7:0] head;
  } rx_status_t;

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);
  localparam int CLOCK_FREQ_HZ = 10_000_000;
  // 115200 baud at the system clock
  localparam logic [15:0] DIV_RESET = 16'(CLOCK_FREQ_HZ / 115200 - 1);
  // Lowest bit of the watermark field in txctrl and rxctrl
  localparam int WM_LSB = 16;

endpackage

`default_nettype wire
